// ==== run.sh ====
#!/bin/sh
# Build and run the boot loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module boot_loader_tb -o boot_loader_sim

status=0
./obj_dir/boot_loader_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation FAILED" sim.log; then
  echo "Simulation run reported a failure, see sim.log"
  exit 1
fi
exit 0

// ==== tests/boot_loader_chk.sv ====
// Target bus and beat buffer assertions, bound into the loader top through its internal nets
`timescale 1ns/10ps
`default_nettype none

module boot_loader_chk (
  input logic                      clk,
  input logic                      rst_i,
  input boot_loader_pkg::tgt_req_t req_i,
  input logic                      req_ready_i,
  input boot_loader_pkg::tgt_rsp_t rsp_i,
  input logic                      push_i,
  input logic                      full_i
);

  logic outstanding_q;

  // Set at request acceptance, cleared by the response
  always_ff @(posedge clk) begin
    if (rst_i) begin
      outstanding_q <= 1'b0;
    end else if (req_i.valid && req_ready_i) begin
      outstanding_q <= 1'b1;
    end else if (rsp_i.valid) begin
      outstanding_q <= 1'b0;
    end
  end

  req_held_until_ready: assert property (@(posedge clk) disable iff (rst_i)
    req_i.valid && !req_ready_i |=> req_i.valid && $stable(req_i))
    else $error("target request changed before it was accepted");

  one_outstanding: assert property (@(posedge clk) disable iff (rst_i)
    outstanding_q |-> !req_i.valid)
    else $error("target request issued while a response is outstanding");

  no_push_when_full: assert property (@(posedge clk) disable iff (rst_i)
    full_i |-> !push_i)
    else $error("beat pushed into a full buffer");

endmodule

bind boot_loader_top boot_loader_chk boot_loader_chk_inst (
  .clk         (clk),
  .rst_i       (rst_i),
  .req_i       (tgt_req_o),
  .req_ready_i (tgt_req_ready_i),
  .rsp_i       (tgt_rsp_i),
  .push_i      (beat_push),
  .full_i      (buf_full)
);

`default_nettype wire

// ==== tests/boot_loader_tb.sv ====
// Driven by tests/boot_loader_tests.txt; R and M commands first wait for the loader to go idle
`timescale 1ns/10ps
`default_nettype none

module boot_loader_tb;
  import boot_loader_pkg::*;

  localparam string TestFile = "tests/boot_loader_tests.txt";
  localparam int unsigned CmdCycles = 600;
  localparam int unsigned BeatCycles = 60;

  logic clk;
  logic rst_i;
  logic s_awvalid;
  logic s_awready;
  reg_off_t s_awaddr;
  logic s_wvalid;
  logic s_wready;
  word_t s_wdata;
  logic s_bvalid;
  logic s_bready;
  logic [1:0] s_bresp;
  logic s_arvalid;
  logic s_arready;
  reg_off_t s_araddr;
  logic s_rvalid;
  logic s_rready;
  word_t s_rdata;
  logic [1:0] s_rresp;
  tgt_req_t tgt_req;
  logic tgt_req_ready;
  tgt_rsp_t tgt_rsp;

  // Target memory model state
  word_t tgt_mem [addr_t];
  logic err_next;
  int unsigned eoc_delay;
  exit_code_t eoc_exit;
  int eoc_countdown;

  string test_name;
  int unsigned budget_cycles;

  boot_loader_top boot_loader_top_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .s_awvalid_i     (s_awvalid),
    .s_awready_o     (s_awready),
    .s_awaddr_i      (s_awaddr),
    .s_wvalid_i      (s_wvalid),
    .s_wready_o      (s_wready),
    .s_wdata_i       (s_wdata),
    .s_bvalid_o      (s_bvalid),
    .s_bready_i      (s_bready),
    .s_bresp_o       (s_bresp),
    .s_arvalid_i     (s_arvalid),
    .s_arready_o     (s_arready),
    .s_araddr_i      (s_araddr),
    .s_rvalid_o      (s_rvalid),
    .s_rready_i      (s_rready),
    .s_rdata_o       (s_rdata),
    .s_rresp_o       (s_rresp),
    .tgt_req_o       (tgt_req),
    .tgt_req_ready_i (tgt_req_ready),
    .tgt_rsp_i       (tgt_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string what, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Handshake sampled at the rising edge, B expected one cycle after acceptance
  task automatic write_reg(input reg_off_t off, input word_t data, output logic [1:0] resp,
                           output int unsigned stalls);
    stalls = 0;
    @(negedge clk);
    s_awvalid = 1'b1;
    s_awaddr = off;
    s_wvalid = 1'b1;
    s_wdata = data;
    @(posedge clk);
    while (!s_awready && !s_wready) begin
      stalls++;
      @(posedge clk);
    end
    check_value("AW and W accepted together", 32'(s_awready), 32'(s_wready));
    @(negedge clk);
    s_awvalid = 1'b0;
    s_wvalid = 1'b0;
    check_value("BVALID one cycle after acceptance", 32'd1, 32'(s_bvalid));
    resp = s_bresp;
  endtask

  task automatic read_reg(input reg_off_t off, output word_t data, output logic [1:0] resp);
    @(negedge clk);
    s_arvalid = 1'b1;
    s_araddr = off;
    @(posedge clk);
    while (!s_arready) begin
      @(posedge clk);
    end
    @(negedge clk);
    s_arvalid = 1'b0;
    check_value("RVALID one cycle after acceptance", 32'd1, 32'(s_rvalid));
    data = s_rdata;
    resp = s_rresp;
  endtask

  task automatic wait_idle();
    word_t status;
    logic [1:0] resp;
    do begin
      read_reg(RegStatus, status, resp);
      check_value("status poll response", 32'(RespOkay), 32'(resp));
    end while (status[0]);
  endtask

  function automatic string strip_line(input string text);
    string result;
    result = text;
    while (result.len() > 0 && (result.getc(result.len() - 1) == "\n" ||
           result.getc(result.len() - 1) == "\r" || result.getc(result.len() - 1) == " ")) begin
      result = result.substr(0, result.len() - 2);
    end
    return result;
  endfunction

  // Cycle allowance for one command line
  function automatic int unsigned line_cycles(input string text);
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    int n;
    int unsigned cycles;
    cycles = CmdCycles;
    n = $sscanf(text.substr(1, text.len() - 1), "%h %h %h %h", a, b, c, d);
    case (text.getc(0))
      "W": if (n >= 4) cycles += d * BeatCycles;
      "M": if (n >= 3) cycles += c * BeatCycles;
      "E": if (n >= 1) cycles += 2 * a;
      default: ;
    endcase
    return cycles;
  endfunction

  task automatic run_command(input string text);
    byte cmd;
    int n;
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t data;
    logic [1:0] resp;
    int unsigned count;
    int unsigned stalls;
    int unsigned stall_total;
    addr_t addr;
    cmd = text.getc(0);
    n = $sscanf(text.substr(1, text.len() - 1), "%h %h %h %h", a, b, c, d);
    case (cmd)
      "T": test_name = text.substr(2, text.len() - 1);
      "W": begin
        count = (n >= 4) ? d : 1;
        stall_total = 0;
        for (int unsigned i = 0; i < count; i++) begin
          write_reg(a[4:0], b + word_t'(i), resp, stalls);
          stall_total += stalls;
          check_value($sformatf("write %h response", a[4:0]), c, 32'(resp));
        end
        // More beats than one burst holds must meet back-pressure
        if (a[4:0] == RegData && count > BurstBeats && stall_total == 0) begin
          $display("Test %s: %0d data beats went in without any stall", test_name, count);
          $display("Simulation FAILED");
          $fatal(1, "no back-pressure seen");
        end
      end
      "R": begin
        wait_idle();
        read_reg(a[4:0], data, resp);
        check_value($sformatf("read %h data", a[4:0]), b, data);
        check_value($sformatf("read %h response", a[4:0]), c, 32'(resp));
      end
      "M": begin
        count = (n >= 3) ? c : 1;
        wait_idle();
        for (int unsigned i = 0; i < count; i++) begin
          addr = a + word_t'(4 * i);
          if (!tgt_mem.exists(addr)) begin
            $display("Test %s: target word at %h was never written", test_name, addr);
            $display("Simulation FAILED");
            $fatal(1, "missing target write");
          end
          check_value($sformatf("memory %h", addr), b + word_t'(i), tgt_mem[addr]);
        end
      end
      "E": begin
        eoc_delay = a;
        eoc_exit = b[30:0];
      end
      "X": err_next = 1'b1;
      default: begin
        $display("Unknown command in the test file: %s", text);
        $display("Simulation FAILED");
        $fatal(1, "bad test file");
      end
    endcase
  endtask

  // Target bus model with random ready and response delays
  initial begin : target_model
    tgt_req_t req;
    logic rsp_err;
    word_t rdata;
    forever begin
      @(negedge clk);
      if (!rst_i && tgt_req.valid) begin
        repeat ($urandom % 6) @(negedge clk);
        tgt_req_ready = 1'b1;
        @(posedge clk);
        req = tgt_req;
        @(negedge clk);
        tgt_req_ready = 1'b0;
        rsp_err = err_next;
        err_next = 1'b0;
        rdata = '0;
        if (!rsp_err && req.we) begin
          tgt_mem[req.addr] = req.wdata;
          if (req.addr == TgtScratch2Addr && req.wdata == LaunchValue) begin
            eoc_countdown = eoc_delay;
          end
        end else if (!rsp_err) begin
          rdata = tgt_mem.exists(req.addr) ? tgt_mem[req.addr] : '0;
        end
        repeat ($urandom % 3) @(negedge clk);
        tgt_rsp = '{valid: 1'b1, err: rsp_err, rdata: rdata};
        @(negedge clk);
        tgt_rsp = '0;
      end
    end
  end

  // Program completion some cycles after the launch value lands
  always @(posedge clk) begin
    if (eoc_countdown == 0) begin
      tgt_mem[TgtScratch2Addr] = {eoc_exit, 1'b1};
    end
    if (eoc_countdown >= 0) begin
      eoc_countdown = eoc_countdown - 1;
    end
  end

  initial begin : watchdog
    wait (budget_cycles != 0);
    repeat (budget_cycles) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", budget_cycles);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    int fd;
    string line;
    string lines[$];
    int unsigned total;
    void'($urandom(94492));
    rst_i = 1'b1;
    s_awvalid = 1'b0;
    s_awaddr = '0;
    s_wvalid = 1'b0;
    s_wdata = '0;
    s_bready = 1'b1;
    s_arvalid = 1'b0;
    s_araddr = '0;
    s_rready = 1'b1;
    tgt_req_ready = 1'b0;
    tgt_rsp = '0;
    err_next = 1'b0;
    eoc_delay = 0;
    eoc_exit = '0;
    eoc_countdown = -1;
    test_name = "none";
    total = 100;
    fd = $fopen(TestFile, "r");
    if (fd == 0) begin
      $display("Cannot open the test file %s", TestFile);
      $display("Simulation FAILED");
      $fatal(1, "no test file");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line = strip_line(line);
      if (line.len() > 0 && line.getc(0) != "#") begin
        lines.push_back(line);
        total += line_cycles(line);
      end
    end
    $fclose(fd);
    budget_cycles = total;
    repeat (5) @(negedge clk);
    rst_i = 1'b0;
    foreach (lines[i]) begin
      run_command(lines[i]);
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/boot_loader_tests.txt ====
# cmd fields in hex: T name | W off data resp [n] | R off data resp | M addr data [n] | E cycles exit | X
# W and M with n repeat over n words with data +1 each; R and M wait until the loader is idle
T burst_of_eight
W 00 00001000 0
W 04 a0000000 0 8
M 00001000 a0000000 8
R 14 00000000 0
T flush_partial
W 00 00002000 0
W 04 b0000000 0 3
W 08 00000000 0
M 00002000 b0000000 3
W 04 b0000003 0 2
W 08 00000000 0
M 0000200c b0000003 2
T backpressure
W 00 00003000 0
W 04 c0000000 0 14
W 08 00000000 0
M 00003000 c0000000 14
T launch_run
E 00000064 0000002a
W 0c 80000000 0
W 10 00000000 0
M 03000000 80000000
M 03000008 00000055
R 14 00000002 0
R 18 0000002a 0
T target_error
W 00 00004000 0
X
W 04 d0000000 0
W 08 00000000 0
R 14 00000006 0
R 18 00000000 0
R 1c 00000000 2
W 14 00000000 2
R 00 00004000 0

// ==== verilog/beat_buffer.sv ====
// Beat FIFO of depth BurstBeats; pushing when full or popping when empty is not guarded
`timescale 1ns/10ps
`default_nettype none

module beat_buffer (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       push_i,
  input  boot_loader_pkg::word_t     push_data_i,
  input  logic                       pop_i,
  output boot_loader_pkg::word_t     head_o,
  output boot_loader_pkg::beat_cnt_t count_o,
  output logic                       full_o,
  output logic                       empty_o
);
  import boot_loader_pkg::*;

  localparam int unsigned PtrW = $clog2(BurstBeats);

  word_t mem_q [BurstBeats];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;

  assign head_o = mem_q[rd_ptr_q];
  assign full_o = (count_o == beat_cnt_t'(BurstBeats));
  assign empty_o = (count_o == '0);

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_o <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(BurstBeats - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(BurstBeats - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_o <= count_o + beat_cnt_t'(push_i) - beat_cnt_t'(pop_i);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/boot_loader_pkg.sv ====
// Shared loader types and constants; 32-bit target addresses only, BurstBeats must stay >= 2
`default_nettype none

package boot_loader_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0] reg_off_t;
  typedef logic [30:0] exit_code_t;

  localparam int unsigned BurstBeats = 8;
  localparam int unsigned PollIdleCycles = 20;
  localparam word_t LaunchValue = 32'd2;

  typedef logic [$clog2(BurstBeats+1)-1:0] beat_cnt_t;

  // Host register map, byte offsets
  localparam reg_off_t RegSecAddr = 5'h00;
  localparam reg_off_t RegData = 5'h04;
  localparam reg_off_t RegFlush = 5'h08;
  localparam reg_off_t RegEntry = 5'h0C;
  localparam reg_off_t RegLaunch = 5'h10;
  localparam reg_off_t RegStatus = 5'h14;
  localparam reg_off_t RegExit = 5'h18;

  // AXI response codes
  localparam logic [1:0] RespOkay = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // Target scratch words used for the launch handshake
  localparam addr_t TgtScratch0Addr = 32'h0300_0000;
  localparam addr_t TgtScratch2Addr = 32'h0300_0008;

  typedef enum logic [1:0] {
    OpBeat,
    OpEntry,
    OpLaunch,
    OpPoll
  } op_e;

  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    word_t wdata;
  } tgt_req_t;

  typedef struct packed {
    logic  valid;
    logic  err;
    word_t rdata;
  } tgt_rsp_t;

  typedef enum logic [2:0] {
    Idle,
    Drain,
    WrEntry,
    WrLaunch,
    PollWait,
    PollRead,
    Done
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== verilog/boot_loader_top.sv ====
// Boot loader top; host side is AXI4-Lite, target side a single-outstanding valid/ready bus
`timescale 1ns/10ps
`default_nettype none

module boot_loader_top (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      s_awvalid_i,
  output logic                      s_awready_o,
  input  boot_loader_pkg::reg_off_t s_awaddr_i,
  input  logic                      s_wvalid_i,
  output logic                      s_wready_o,
  input  boot_loader_pkg::word_t    s_wdata_i,
  output logic                      s_bvalid_o,
  input  logic                      s_bready_i,
  output logic [1:0]                s_bresp_o,
  input  logic                      s_arvalid_i,
  output logic                      s_arready_o,
  input  boot_loader_pkg::reg_off_t s_araddr_i,
  output logic                      s_rvalid_o,
  input  logic                      s_rready_i,
  output boot_loader_pkg::word_t    s_rdata_o,
  output logic [1:0]                s_rresp_o,
  output boot_loader_pkg::tgt_req_t tgt_req_o,
  input  logic                      tgt_req_ready_i,
  input  boot_loader_pkg::tgt_rsp_t tgt_rsp_i
);
  import boot_loader_pkg::*;

  logic beat_push;
  word_t beat_data;
  logic buf_full;
  logic buf_empty;
  beat_cnt_t beat_count;
  word_t head;
  logic sec_addr_load;
  addr_t sec_addr;
  word_t entry;
  logic flush_req;
  logic launch_req;
  logic pop;
  logic op_valid;
  op_e op;
  logic op_done;
  logic op_err;
  word_t rdata;
  logic poll_start;
  logic poll_due;
  logic eoc;
  exit_code_t exit_code;
  logic busy;
  logic done;
  logic error;

  loader_regs loader_regs_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .s_awvalid_i     (s_awvalid_i),
    .s_awready_o     (s_awready_o),
    .s_awaddr_i      (s_awaddr_i),
    .s_wvalid_i      (s_wvalid_i),
    .s_wready_o      (s_wready_o),
    .s_wdata_i       (s_wdata_i),
    .s_bvalid_o      (s_bvalid_o),
    .s_bready_i      (s_bready_i),
    .s_bresp_o       (s_bresp_o),
    .s_arvalid_i     (s_arvalid_i),
    .s_arready_o     (s_arready_o),
    .s_araddr_i      (s_araddr_i),
    .s_rvalid_o      (s_rvalid_o),
    .s_rready_i      (s_rready_i),
    .s_rdata_o       (s_rdata_o),
    .s_rresp_o       (s_rresp_o),
    .buf_full_i      (buf_full),
    .beat_push_o     (beat_push),
    .beat_data_o     (beat_data),
    .sec_addr_load_o (sec_addr_load),
    .sec_addr_o      (sec_addr),
    .entry_o         (entry),
    .flush_req_o     (flush_req),
    .launch_req_o    (launch_req),
    .busy_i          (busy),
    .done_i          (done),
    .error_i         (error),
    .exit_code_i     (exit_code)
  );

  beat_buffer beat_buffer_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .push_i      (beat_push),
    .push_data_i (beat_data),
    .pop_i       (pop),
    .head_o      (head),
    .count_o     (beat_count),
    .full_o      (buf_full),
    .empty_o     (buf_empty)
  );

  loader_ctrl loader_ctrl_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .flush_req_i  (flush_req),
    .launch_req_i (launch_req),
    .count_i      (beat_count),
    .empty_i      (buf_empty),
    .pop_o        (pop),
    .op_valid_o   (op_valid),
    .op_o         (op),
    .op_done_i    (op_done),
    .op_err_i     (op_err),
    .poll_start_o (poll_start),
    .poll_due_i   (poll_due),
    .eoc_i        (eoc),
    .busy_o       (busy),
    .done_o       (done),
    .error_o      (error)
  );

  target_bus_master target_bus_master_inst (
    .clk             (clk),
    .rst_i           (rst_i),
    .sec_addr_load_i (sec_addr_load),
    .sec_addr_i      (sec_addr),
    .op_valid_i      (op_valid),
    .op_i            (op),
    .beat_i          (head),
    .entry_i         (entry),
    .tgt_req_o       (tgt_req_o),
    .tgt_req_ready_i (tgt_req_ready_i),
    .tgt_rsp_i       (tgt_rsp_i),
    .op_done_o       (op_done),
    .op_err_o        (op_err),
    .rdata_o         (rdata)
  );

  eoc_poller eoc_poller_inst (
    .clk          (clk),
    .rst_i        (rst_i),
    .poll_start_i (poll_start),
    .rd_valid_i   (op_done),
    .rdata_i      (rdata),
    .poll_due_o   (poll_due),
    .eoc_o        (eoc),
    .exit_code_o  (exit_code)
  );

endmodule

`default_nettype wire

// ==== verilog/eoc_poller.sv ====
// Poll timer and completion capture; every response overwrites the flag and the exit code
`timescale 1ns/10ps
`default_nettype none

module eoc_poller (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        poll_start_i,
  input  logic                        rd_valid_i,
  input  boot_loader_pkg::word_t      rdata_i,
  output logic                        poll_due_o,
  output logic                        eoc_o,
  output boot_loader_pkg::exit_code_t exit_code_o
);
  import boot_loader_pkg::*;

  localparam int unsigned CntW = $clog2(PollIdleCycles);

  logic running_q;
  logic [CntW-1:0] cnt_q;

  // Due exactly PollIdleCycles cycles after the start pulse
  assign poll_due_o = running_q && (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      running_q <= 1'b0;
      cnt_q <= '0;
      eoc_o <= 1'b0;
      exit_code_o <= '0;
    end else begin
      if (poll_start_i) begin
        running_q <= 1'b1;
        cnt_q <= CntW'(PollIdleCycles - 1);
      end else if (poll_due_o) begin
        running_q <= 1'b0;
      end else if (running_q) begin
        cnt_q <= cnt_q - 1'b1;
      end
      // Bit 0 flags completion, the rest is the exit code
      if (rd_valid_i) begin
        eoc_o <= rdata_i[0];
        exit_code_o <= rdata_i[31:1];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/loader_ctrl.sv ====
// Loader sequencer; one operation in flight, and a drain runs until the buffer is empty
`timescale 1ns/10ps
`default_nettype none

module loader_ctrl (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       flush_req_i,
  input  logic                       launch_req_i,
  input  boot_loader_pkg::beat_cnt_t count_i,
  input  logic                       empty_i,
  output logic                       pop_o,
  output logic                       op_valid_o,
  output boot_loader_pkg::op_e       op_o,
  input  logic                       op_done_i,
  input  logic                       op_err_i,
  output logic                       poll_start_o,
  input  logic                       poll_due_i,
  input  logic                       eoc_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic                       error_o
);
  import boot_loader_pkg::*;

  ctrl_state_e state_q;
  logic pending_q;
  logic flush_pend_q;
  logic launch_pend_q;
  logic rest;

  assign rest = (state_q == Idle) || (state_q == Done);

  always_comb begin
    case (state_q)
      WrEntry:  op_o = OpEntry;
      WrLaunch: op_o = OpLaunch;
      PollRead: op_o = OpPoll;
      default:  op_o = OpBeat;
    endcase
  end

  assign op_valid_o = !pending_q && ((state_q == Drain) ? !empty_i :
                      (state_q == WrEntry) || (state_q == WrLaunch) || (state_q == PollRead));
  assign pop_o = (state_q == Drain) && op_done_i;
  // Timer restarts after the launch write and after every poll that read back
  assign poll_start_o = op_done_i && !op_err_i &&
                        ((state_q == WrLaunch) || (state_q == PollRead));

  // Pending commands count as busy so the host never reads a stale idle
  assign busy_o = !rest || !empty_i || flush_pend_q || launch_pend_q;
  assign done_o = (state_q == Done);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= Idle;
      pending_q <= 1'b0;
      flush_pend_q <= 1'b0;
      launch_pend_q <= 1'b0;
      error_o <= 1'b0;
    end else begin
      if (op_valid_o) begin
        pending_q <= 1'b1;
      end else if (op_done_i) begin
        pending_q <= 1'b0;
      end
      if (flush_req_i) begin
        flush_pend_q <= 1'b1;
      end else if (rest) begin
        flush_pend_q <= 1'b0;
      end
      if (launch_req_i) begin
        launch_pend_q <= 1'b1;
      end
      // Any error response ends the run
      if (op_done_i && op_err_i) begin
        state_q <= Done;
        error_o <= 1'b1;
      end else begin
        case (state_q)
          Idle, Done: begin
            if (count_i == beat_cnt_t'(BurstBeats) || (flush_pend_q && !empty_i)) begin
              state_q <= Drain;
              error_o <= 1'b0;
            end else if (launch_pend_q && empty_i) begin
              state_q <= WrEntry;
              launch_pend_q <= 1'b0;
              error_o <= 1'b0;
            end
          end
          Drain: begin
            if (!pending_q && empty_i) begin
              state_q <= Idle;
            end
          end
          WrEntry: begin
            if (op_done_i) begin
              state_q <= WrLaunch;
            end
          end
          WrLaunch, PollRead: begin
            if (op_done_i) begin
              state_q <= PollWait;
            end
          end
          PollWait: begin
            if (eoc_i) begin
              state_q <= Done;
            end else if (poll_due_i) begin
              state_q <= PollRead;
            end
          end
          default: state_q <= Idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/loader_regs.sv ====
// AXI4-Lite host registers; full 32-bit accesses only, strobes and prot are not supported
`timescale 1ns/10ps
`default_nettype none

module loader_regs (
  input  logic                        clk,
  input  logic                        rst_i,
  input  logic                        s_awvalid_i,
  output logic                        s_awready_o,
  input  boot_loader_pkg::reg_off_t   s_awaddr_i,
  input  logic                        s_wvalid_i,
  output logic                        s_wready_o,
  input  boot_loader_pkg::word_t      s_wdata_i,
  output logic                        s_bvalid_o,
  input  logic                        s_bready_i,
  output logic [1:0]                  s_bresp_o,
  input  logic                        s_arvalid_i,
  output logic                        s_arready_o,
  input  boot_loader_pkg::reg_off_t   s_araddr_i,
  output logic                        s_rvalid_o,
  input  logic                        s_rready_i,
  output boot_loader_pkg::word_t      s_rdata_o,
  output logic [1:0]                  s_rresp_o,
  input  logic                        buf_full_i,
  output logic                        beat_push_o,
  output boot_loader_pkg::word_t      beat_data_o,
  output logic                        sec_addr_load_o,
  output boot_loader_pkg::addr_t      sec_addr_o,
  output boot_loader_pkg::word_t      entry_o,
  output logic                        flush_req_o,
  output logic                        launch_req_o,
  input  logic                        busy_i,
  input  logic                        done_i,
  input  logic                        error_i,
  input  boot_loader_pkg::exit_code_t exit_code_i
);
  import boot_loader_pkg::*;

  logic wr_block;
  logic wr_acc;
  logic rd_acc;

  // Back-pressure: data writes wait while the buffer is full
  assign wr_block = (s_awaddr_i == RegData) && buf_full_i;
  assign wr_acc = s_awvalid_i && s_wvalid_i && !s_bvalid_o && !wr_block;
  assign rd_acc = s_arvalid_i && !s_rvalid_o;

  assign s_awready_o = wr_acc;
  assign s_wready_o = wr_acc;
  assign s_arready_o = !s_rvalid_o;

  assign beat_push_o = wr_acc && (s_awaddr_i == RegData);
  assign beat_data_o = s_wdata_i;

  // Handshake flags and one-cycle command pulses
  always_ff @(posedge clk) begin
    if (rst_i) begin
      s_bvalid_o <= 1'b0;
      s_rvalid_o <= 1'b0;
      sec_addr_load_o <= 1'b0;
      flush_req_o <= 1'b0;
      launch_req_o <= 1'b0;
    end else begin
      sec_addr_load_o <= 1'b0;
      flush_req_o <= 1'b0;
      launch_req_o <= 1'b0;
      if (s_bvalid_o && s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
      if (s_rvalid_o && s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
      if (wr_acc) begin
        s_bvalid_o <= 1'b1;
        case (s_awaddr_i)
          RegSecAddr: sec_addr_load_o <= 1'b1;
          RegFlush:   flush_req_o <= 1'b1;
          // A launch during a run is dropped
          RegLaunch:  launch_req_o <= !busy_i;
          default: ;
        endcase
      end
      if (rd_acc) begin
        s_rvalid_o <= 1'b1;
      end
    end
  end

  // Register contents and response payload
  always_ff @(posedge clk) begin
    if (wr_acc) begin
      s_bresp_o <= RespOkay;
      case (s_awaddr_i)
        RegSecAddr: sec_addr_o <= s_wdata_i;
        RegEntry:   entry_o <= s_wdata_i;
        RegData, RegFlush, RegLaunch: ;
        default:    s_bresp_o <= RespSlvErr;
      endcase
    end
    if (rd_acc) begin
      s_rresp_o <= RespOkay;
      case (s_araddr_i)
        RegSecAddr: s_rdata_o <= sec_addr_o;
        RegEntry:   s_rdata_o <= entry_o;
        RegStatus:  s_rdata_o <= {29'd0, error_i, done_i, busy_i};
        RegExit:    s_rdata_o <= {1'b0, exit_code_i};
        RegData, RegFlush, RegLaunch: s_rdata_o <= '0;
        default: begin
          s_rdata_o <= '0;
          s_rresp_o <= RespSlvErr;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== verilog/target_bus_master.sv ====
// Target bus master; one request outstanding, and a response must come at least a cycle after ready
`timescale 1ns/10ps
`default_nettype none

module target_bus_master (
  input  logic                      clk,
  input  logic                      rst_i,
  input  logic                      sec_addr_load_i,
  input  boot_loader_pkg::addr_t    sec_addr_i,
  input  logic                      op_valid_i,
  input  boot_loader_pkg::op_e      op_i,
  input  boot_loader_pkg::word_t    beat_i,
  input  boot_loader_pkg::word_t    entry_i,
  output boot_loader_pkg::tgt_req_t tgt_req_o,
  input  logic                      tgt_req_ready_i,
  input  boot_loader_pkg::tgt_rsp_t tgt_rsp_i,
  output logic                      op_done_o,
  output logic                      op_err_o,
  output boot_loader_pkg::word_t    rdata_o
);
  import boot_loader_pkg::*;

  logic req_valid_q;
  logic wait_rsp_q;
  logic we_q;
  addr_t addr_q;
  word_t wdata_q;
  addr_t sec_cnt_q;
  logic issue;

  assign issue = op_valid_i && !req_valid_q && !wait_rsp_q;

  assign tgt_req_o = '{valid: req_valid_q, we: we_q, addr: addr_q, wdata: wdata_q};

  assign op_done_o = wait_rsp_q && tgt_rsp_i.valid;
  assign op_err_o = tgt_rsp_i.err;
  // Writes return zero so the poller never sees stale read data
  assign rdata_o = we_q ? '0 : tgt_rsp_i.rdata;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      req_valid_q <= 1'b0;
      wait_rsp_q <= 1'b0;
    end else if (issue) begin
      req_valid_q <= 1'b1;
    end else if (req_valid_q && tgt_req_ready_i) begin
      req_valid_q <= 1'b0;
      wait_rsp_q <= 1'b1;
    end else if (op_done_o) begin
      wait_rsp_q <= 1'b0;
    end
  end

  // Request payload and section address counter
  always_ff @(posedge clk) begin
    if (sec_addr_load_i) begin
      sec_cnt_q <= sec_addr_i;
    end
    if (issue) begin
      we_q <= (op_i != OpPoll);
      case (op_i)
        OpBeat: begin
          addr_q <= sec_cnt_q;
          wdata_q <= beat_i;
          sec_cnt_q <= sec_cnt_q + 32'd4;
        end
        OpEntry: begin
          addr_q <= TgtScratch0Addr;
          wdata_q <= entry_i;
        end
        OpLaunch: begin
          addr_q <= TgtScratch2Addr;
          wdata_q <= LaunchValue;
        end
        default: begin
          addr_q <= TgtScratch2Addr;
          wdata_q <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/boot_loader_pkg.sv
verilog/loader_regs.sv
verilog/beat_buffer.sv
verilog/loader_ctrl.sv
verilog/target_bus_master.sv
verilog/eoc_poller.sv
verilog/boot_loader_top.sv
tests/boot_loader_chk.sv
tests/boot_loader_tb.sv
